// ==== logic/mmu_pkg.sv ====
/*
  Shared widths, Wishbone register map and TLB entry word layouts.
  Pages are fixed at 4 KB, so VPN and PPN are both 20 bits wide.
*/
package mmu_pkg;

  localparam int VA_W       = 32;
  localparam int PAGE_OFS_W = 12;
  localparam int VPN_W      = VA_W - PAGE_OFS_W;
  localparam int PPN_W      = 20;
  localparam int ASID_W     = 10;
  localparam int WB_ADR_W   = 3;
  localparam int WB_DAT_W   = 32;

  // Register map in word addresses
  localparam logic [WB_ADR_W-1:0] ADR_INDEX = 3'd0;
  localparam logic [WB_ADR_W-1:0] ADR_TAG   = 3'd1;
  localparam logic [WB_ADR_W-1:0] ADR_DATA  = 3'd2;
  localparam logic [WB_ADR_W-1:0] ADR_ASID  = 3'd3;
  localparam logic [WB_ADR_W-1:0] ADR_CMD   = 3'd4;

  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic              g;
    logic              rsvd;
  } tlb_tag_t;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic [9:0]       rsvd;
    logic             v;
    logic             d;
  } tlb_data_t;

  // Bus write word, read as tag or data depending on address
  typedef union packed {
    tlb_tag_t            tag;
    tlb_data_t           data;
    logic [WB_DAT_W-1:0] raw;
  } tlb_wdata_u;

endpackage

// ==== logic/mmu_tlb_top.sv ====
/*
  TLB top level with a Wishbone maintenance port and a lookup port.
  One lookup per cycle, no stall; response follows req_vld by two cycles.
  NUM_ENTRIES must be a power of two from 4 to 64.
*/
`timescale 1ns/1ps

module mmu_tlb_top #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                         forever_cpuclk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [mmu_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [mmu_pkg::WB_DAT_W-1:0] wb_dat_w,
  output logic [mmu_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack,
  input  logic                         req_vld,
  input  logic [mmu_pkg::VA_W-1:0]     req_va,
  input  logic                         req_st,
  output logic                         rsp_vld,
  output logic [mmu_pkg::VA_W-1:0]     rsp_pa,
  output logic                         rsp_miss,
  output logic                         rsp_fault
);
  import mmu_pkg::*;

  logic [NUM_ENTRIES-1:0]             hit_vec;
  logic [NUM_ENTRIES-1:0]             v_vec;
  logic [NUM_ENTRIES-1:0]             d_vec;
  logic [NUM_ENTRIES-1:0][PPN_W-1:0]  ppn_vec;

  tlb_maint_if #(.NUM_ENTRIES(NUM_ENTRIES)) maint_bus ();
  tlb_lookup_if                             lookup_bus ();

  tlb_ctrl #(.NUM_ENTRIES(NUM_ENTRIES)) ctrl_i (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .req_vld        (req_vld),
    .req_st         (req_st),
    .req_va         (req_va),
    .maint          (maint_bus.ctrl),
    .lookup         (lookup_bus.ctrl)
  );

  //============================================================
  // Entry array
  //============================================================
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    tlb_entry #(.ENTRY_IDX(i)) entry_i (
      .forever_cpuclk (forever_cpuclk),
      .rst_n          (rst_n),
      .maint          (maint_bus.entry),
      .lookup         (lookup_bus.entry),
      .hit            (hit_vec[i]),
      .ppn            (ppn_vec[i]),
      .v              (v_vec[i]),
      .d              (d_vec[i])
    );
  end

  tlb_hit_sel #(.NUM_ENTRIES(NUM_ENTRIES)) hit_sel_i (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .lookup         (lookup_bus.sel),
    .hit            (hit_vec),
    .v              (v_vec),
    .d              (d_vec),
    .ppn            (ppn_vec),
    .rsp_vld        (rsp_vld),
    .rsp_miss       (rsp_miss),
    .rsp_fault      (rsp_fault),
    .rsp_pa         (rsp_pa)
  );

endmodule

// ==== logic/tlb_ctrl.sv ====
/*
  Wishbone classic slave for TLB maintenance, one-cycle ack, no wait states.
  Writes to TAG only stage the tag; a DATA write commits both to entry INDEX.
  Requests are registered onto the lookup bus with the ASID of that cycle.
*/
`timescale 1ns/1ps

module tlb_ctrl #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                         forever_cpuclk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [mmu_pkg::WB_ADR_W-1:0] wb_adr,
  input  mmu_pkg::tlb_wdata_u          wb_dat_w,
  output logic [mmu_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack,
  input  logic                         req_vld,
  input  logic                         req_st,
  input  logic [mmu_pkg::VA_W-1:0]     req_va,
  tlb_maint_if.ctrl                    maint,
  tlb_lookup_if.ctrl                   lookup
);
  import mmu_pkg::*;

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  logic                bus_req;
  logic                wr_stb;
  logic [IDX_W-1:0]    index_q;
  logic [ASID_W-1:0]   asid_q;
  tlb_tag_t            tag_q;
  logic [WB_DAT_W-1:0] rd_mux;

  //============================================================
  // Wishbone handshake
  //============================================================
  assign bus_req = wb_cyc & wb_stb & ~wb_ack;
  assign wr_stb  = bus_req & wb_we;

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= bus_req;
    end
  end

  always_comb begin
    case (wb_adr)
      ADR_INDEX: rd_mux = WB_DAT_W'(index_q);
      ADR_ASID:  rd_mux = WB_DAT_W'(asid_q);
      default:   rd_mux = '0;
    endcase
  end

  always_ff @(posedge forever_cpuclk) begin
    if (bus_req && !wb_we) begin
      wb_dat_r <= rd_mux;
    end
  end

  //============================================================
  // Registers
  //============================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      index_q <= '0;
      asid_q  <= '0;
    end else if (wr_stb) begin
      if (wb_adr == ADR_INDEX) begin
        index_q <= wb_dat_w.raw[IDX_W-1:0];
      end
      if (wb_adr == ADR_ASID) begin
        asid_q <= wb_dat_w.raw[ASID_W-1:0];
      end
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (wr_stb && wb_adr == ADR_TAG) begin
      tag_q <= wb_dat_w.tag;
    end
  end

  // Strobes land on the ack cycle
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      maint.wr_en    <= 1'b0;
      maint.inv_all  <= 1'b0;
      maint.inv_asid <= 1'b0;
    end else begin
      maint.wr_en    <= wr_stb && (wb_adr == ADR_DATA);
      maint.inv_all  <= wr_stb && (wb_adr == ADR_CMD) && wb_dat_w.raw[0];
      maint.inv_asid <= wr_stb && (wb_adr == ADR_CMD) && wb_dat_w.raw[1];
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (wr_stb && wb_adr == ADR_DATA) begin
      maint.wr_idx  <= index_q;
      maint.wr_tag  <= tag_q;
      maint.wr_data <= wb_dat_w.data;
    end
  end

  assign maint.cur_asid = asid_q;

  //============================================================
  // Lookup feeder
  //============================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      lookup.vld <= 1'b0;
    end else begin
      lookup.vld <= req_vld;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    lookup.vpn  <= req_va[VA_W-1:PAGE_OFS_W];
    lookup.ofs  <= req_va[PAGE_OFS_W-1:0];
    lookup.asid <= asid_q;
    lookup.st   <= req_st;
  end

endmodule

// ==== logic/tlb_entry.sv ====
/*
  One fully associative TLB entry for a 4 KB page.
  Match result and fields are registered one cycle after the lookup bus.
*/
`timescale 1ns/1ps

module tlb_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                      forever_cpuclk,
  input  logic                      rst_n,
  tlb_maint_if.entry                maint,
  tlb_lookup_if.entry               lookup,
  output logic                      hit,
  output logic [mmu_pkg::PPN_W-1:0] ppn,
  output logic                      v,
  output logic                      d
);
  import mmu_pkg::*;

  tlb_tag_t  tag_q;
  tlb_data_t data_q;
  logic      present;
  logic      sel_wr;
  logic      asid_kill;
  logic      match;

  assign sel_wr    = maint.wr_en && (int'(maint.wr_idx) == ENTRY_IDX);
  // Global pages survive an ASID flush
  assign asid_kill = maint.inv_asid && !tag_q.g && (tag_q.asid == maint.cur_asid);

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      present <= 1'b0;
    end else if (sel_wr) begin
      present <= 1'b1;
    end else if (maint.inv_all || asid_kill) begin
      present <= 1'b0;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (sel_wr) begin
      tag_q  <= maint.wr_tag;
      data_q <= maint.wr_data;
    end
  end

  assign match = present && (tag_q.vpn == lookup.vpn)
                 && (tag_q.g || (tag_q.asid == lookup.asid));

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= lookup.vld && match;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    ppn <= data_q.ppn;
    v   <= data_q.v;
    d   <= data_q.d;
  end

endmodule

// ==== logic/tlb_hit_sel.sv ====
/*
  Priority select over the registered entry matches; lowest index wins.
  The response is formed from the match stage, two cycles after req_vld.
  Miss and fault outputs force the physical address to zero.
*/
`timescale 1ns/1ps

module tlb_hit_sel #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                                        forever_cpuclk,
  input  logic                                        rst_n,
  tlb_lookup_if.sel                                   lookup,
  input  logic [NUM_ENTRIES-1:0]                      hit,
  input  logic [NUM_ENTRIES-1:0]                      v,
  input  logic [NUM_ENTRIES-1:0]                      d,
  input  logic [NUM_ENTRIES-1:0][mmu_pkg::PPN_W-1:0]  ppn,
  output logic                                        rsp_vld,
  output logic                                        rsp_miss,
  output logic                                        rsp_fault,
  output logic [mmu_pkg::VA_W-1:0]                    rsp_pa
);
  import mmu_pkg::*;

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  logic                  vld_q;
  logic                  st_q;
  logic [PAGE_OFS_W-1:0] ofs_q;
  logic                  any_hit;
  logic [IDX_W-1:0]      hit_idx;
  logic                  fault;

  //============================================================
  // Align request with the entry match stage
  //============================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= lookup.vld;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    st_q  <= lookup.st;
    ofs_q <= lookup.ofs;
  end

  //============================================================
  // Hit select and permission check
  //============================================================
  always_comb begin
    any_hit = 1'b0;
    hit_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        any_hit = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  // Invalid page, or store to a clean page
  assign fault = any_hit && (!v[hit_idx] || (st_q && !d[hit_idx]));

  assign rsp_vld   = vld_q;
  assign rsp_miss  = vld_q && !any_hit;
  assign rsp_fault = vld_q && fault;
  assign rsp_pa    = (vld_q && any_hit && !fault) ? {ppn[hit_idx], ofs_q} : '0;

endmodule

// ==== logic/tlb_if.sv ====
/*
  Buses between the TLB controller and the entry array.
  Maintenance strobes are single-cycle pulses; lookup is broadcast to all entries.
*/
`timescale 1ns/1ps

interface tlb_maint_if #(
  parameter int NUM_ENTRIES = 16
) ();
  import mmu_pkg::*;

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  logic              wr_en;
  logic [IDX_W-1:0]  wr_idx;
  tlb_tag_t          wr_tag;
  tlb_data_t         wr_data;
  logic              inv_all;
  logic              inv_asid;
  logic [ASID_W-1:0] cur_asid;

  modport ctrl (
    output wr_en, wr_idx, wr_tag, wr_data, inv_all, inv_asid, cur_asid
  );

  modport entry (
    input wr_en, wr_idx, wr_tag, wr_data, inv_all, inv_asid, cur_asid
  );
endinterface

interface tlb_lookup_if ();
  import mmu_pkg::*;

  logic                  vld;
  logic [VPN_W-1:0]      vpn;
  logic [PAGE_OFS_W-1:0] ofs;
  logic [ASID_W-1:0]     asid;
  logic                  st;

  modport ctrl  (output vld, vpn, ofs, asid, st);
  modport entry (input vld, vpn, asid);
  modport sel   (input vld, ofs, st);
endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TLB testbench with Verilator; exit status reflects the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mmu_tlb -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi

exit 0

// ==== testbench/tb_mmu_tlb.sv ====
/*
  Testbench top for mmu_tlb_top with 16 entries.
  Inputs are driven 2 ns after the rising edge; the checker compares lookups.
  The run is capped at 4000 cycles.
*/
`timescale 1ns/1ps

module tb_mmu_tlb;
  import mmu_pkg::*;

  localparam int NUM_ENTRIES = 16;
  localparam int MAX_CYCLES  = 4000;

  logic                forever_cpuclk;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_ack;
  logic                req_vld;
  logic [VA_W-1:0]     req_va;
  logic                req_st;
  logic                rsp_vld;
  logic [VA_W-1:0]     rsp_pa;
  logic                rsp_miss;
  logic                rsp_fault;

  integer seed;
  int     cycles;
  int     tb_errs;
  int     errs_before;
  logic [WB_DAT_W-1:0] rd_val;

  mmu_tlb_top #(.NUM_ENTRIES(NUM_ENTRIES)) dut_i (.*);

  tlb_checker #(.NUM_ENTRIES(NUM_ENTRIES)) chk_i (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_ack         (wb_ack),
    .req_vld        (req_vld),
    .req_va         (req_va),
    .req_st         (req_st),
    .rsp_vld        (rsp_vld),
    .rsp_pa         (rsp_pa),
    .rsp_miss       (rsp_miss),
    .rsp_fault      (rsp_fault)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #20 forever_cpuclk = ~forever_cpuclk;
    end
  end

  always @(posedge forever_cpuclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int total_errs();
    return tb_errs + chk_i.err_cnt;
  endfunction

  function automatic logic [31:0] make_tag(input logic [19:0] vpn, input logic [9:0] asid,
                                           input logic g);
    return {vpn, asid, g, 1'b0};
  endfunction

  function automatic logic [31:0] make_data(input logic [19:0] ppn, input logic v,
                                            input logic d);
    return {ppn, 10'd0, v, d};
  endfunction

  //============================================================
  // Bus and lookup drivers
  //============================================================
  task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    @(posedge forever_cpuclk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    forever begin
      @(posedge forever_cpuclk);
      #2;
      if (wb_ack) break;
    end
    rdat = wb_dat_r;
    // Held through the edge that samples ack
    @(posedge forever_cpuclk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic reg_expect(input logic [WB_ADR_W-1:0] adr, input logic [31:0] exp_val);
    bus_cycle(1'b0, adr, 32'd0, rd_val);
    if (rd_val !== exp_val) begin
      $display("Fail at %0t: wb_dat_r (adr %0d) expected %h, got %h",
               $time, adr, exp_val, rd_val);
      tb_errs++;
    end
  endtask

  task automatic write_entry(input int idx, input logic [31:0] tag, input logic [31:0] data);
    reg_write(ADR_INDEX, 32'(idx));
    reg_write(ADR_TAG, tag);
    reg_write(ADR_DATA, data);
  endtask

  task automatic lookup_one(input logic [31:0] va, input logic st);
    @(posedge forever_cpuclk);
    #2;
    req_vld = 1'b1;
    req_va  = va;
    req_st  = st;
  endtask

  task automatic lookups_done();
    @(posedge forever_cpuclk);
    #2;
    req_vld = 1'b0;
    repeat (3) @(posedge forever_cpuclk);
  endtask

  task automatic sweep_vpns(input logic st);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      lookup_one({20'h40000 + 20'(i), 12'($random(seed))}, st);
    end
    lookups_done();
  endtask

  task automatic report(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, total_errs() - errs_before);
    errs_before = total_errs();
  endtask

  //============================================================
  // Test sequence
  //============================================================
  initial begin
    seed        = 61;
    cycles      = 0;
    tb_errs     = 0;
    errs_before = 0;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    req_vld     = 1'b0;
    req_va      = '0;
    req_st      = 1'b0;
    repeat (5) @(posedge forever_cpuclk);
    #2;
    rst_n = 1'b1;

    // Empty after reset
    for (int i = 0; i < 20; i++) begin
      lookup_one(32'($random(seed)), 1'($random(seed)));
    end
    lookups_done();
    reg_expect(ADR_INDEX, 32'd0);
    reg_expect(ADR_ASID, 32'd0);
    report(1, "reset state");

    // Fill all entries with even ones global
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      write_entry(i, make_tag(20'h40000 + 20'(i), 10'd0, (i % 2) == 0),
                  make_data(20'h80000 + 20'(i * 3), 1'b1, 1'b1));
    end
    sweep_vpns(1'b0);
    sweep_vpns(1'b1);
    reg_expect(ADR_INDEX, 32'(NUM_ENTRIES - 1));
    reg_expect(ADR_ASID, 32'd0);
    report(2, "fill and translate");

    // Other ASID leaves only global pages
    reg_write(ADR_ASID, 32'd5);
    reg_expect(ADR_ASID, 32'd5);
    sweep_vpns(1'b0);
    report(3, "asid switch");

    // Permission faults
    write_entry(3, make_tag(20'h40003, 10'd5, 1'b0), make_data(20'h12345, 1'b1, 1'b0));
    write_entry(4, make_tag(20'h40004, 10'd5, 1'b0), make_data(20'h23456, 1'b0, 1'b1));
    lookup_one(32'h40003abc, 1'b1);
    lookup_one(32'h40003abc, 1'b0);
    lookup_one(32'h40004123, 1'b0);
    lookup_one(32'h40004123, 1'b1);
    lookups_done();
    report(4, "faults");

    // ASID flush then flush all
    reg_write(ADR_ASID, 32'd7);
    write_entry(0, make_tag(20'h40000, 10'd7, 1'b0), make_data(20'h00100, 1'b1, 1'b1));
    write_entry(1, make_tag(20'h40001, 10'd7, 1'b1), make_data(20'h00101, 1'b1, 1'b1));
    write_entry(2, make_tag(20'h40002, 10'd3, 1'b0), make_data(20'h00102, 1'b1, 1'b1));
    write_entry(3, make_tag(20'h40003, 10'd7, 1'b0), make_data(20'h00103, 1'b1, 1'b1));
    sweep_vpns(1'b0);
    reg_write(ADR_CMD, 32'd2);
    sweep_vpns(1'b0);
    reg_write(ADR_ASID, 32'd3);
    sweep_vpns(1'b0);
    reg_write(ADR_CMD, 32'd1);
    sweep_vpns(1'b0);
    report(5, "invalidate");

    // Back-to-back lookups with rewrites in flight
    fork
      begin
        for (int i = 0; i < 400; i++) begin
          lookup_one({20'h40000 + 20'($random(seed) & 31), 12'($random(seed))},
                     1'($random(seed)));
        end
        lookups_done();
      end
      begin
        for (int i = 0; i < 40; i++) begin
          write_entry($random(seed) & (NUM_ENTRIES - 1),
                      make_tag(20'h40000 + 20'($random(seed) & 31), 10'($random(seed) & 3),
                               1'($random(seed))),
                      make_data(20'($random(seed)), 1'($random(seed) | $random(seed)),
                                1'($random(seed))));
          if (i % 10 == 9) begin
            reg_write(ADR_ASID, 32'($random(seed) & 3));
          end
        end
      end
    join
    report(6, "random traffic");

    if (chk_i.pending() != 0) begin
      $display("Responses missing for %0d lookups at end of run", chk_i.pending());
      tb_errs++;
    end
    $display("checks: %0d, errors: %0d", chk_i.chk_cnt, total_errs());
    if (total_errs() == 0 && chk_i.chk_cnt > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/tlb_bus_assert.sv ====
/*
  Handshake and response timing rules for mmu_tlb_top, bound into the DUT.
*/
`timescale 1ns/1ps

module tlb_bus_assert (
  input logic forever_cpuclk,
  input logic rst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic req_vld,
  input logic rsp_vld,
  input logic rsp_miss,
  input logic rsp_fault
);

  ack_needs_req: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb)) else $error("ack without cyc and stb");

  ack_one_cycle: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    wb_ack |=> !wb_ack) else $error("ack held longer than one cycle");

  rsp_latency: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    req_vld |-> ##2 rsp_vld) else $error("rsp_vld missing two cycles after req_vld");

  rsp_no_extra: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    rsp_vld |-> $past(req_vld, 2)) else $error("rsp_vld without a request");

  miss_xor_fault: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    !(rsp_miss && rsp_fault)) else $error("miss and fault both high");

endmodule

bind mmu_tlb_top tlb_bus_assert bus_assert_i (.*);

// ==== testbench/tlb_checker.sv ====
/*
  Reference model of the TLB, built by snooping Wishbone writes at ack.
  All DUT signals are sampled on the falling edge.
*/
`timescale 1ns/1ps

module tlb_checker #(
  parameter int NUM_ENTRIES = 16
) (
  input logic                         forever_cpuclk,
  input logic                         rst_n,
  input logic                         wb_cyc,
  input logic                         wb_stb,
  input logic                         wb_we,
  input logic [mmu_pkg::WB_ADR_W-1:0] wb_adr,
  input logic [mmu_pkg::WB_DAT_W-1:0] wb_dat_w,
  input logic                         wb_ack,
  input logic                         req_vld,
  input logic [mmu_pkg::VA_W-1:0]     req_va,
  input logic                         req_st,
  input logic                         rsp_vld,
  input logic [mmu_pkg::VA_W-1:0]     rsp_pa,
  input logic                         rsp_miss,
  input logic                         rsp_fault
);
  import mmu_pkg::*;

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  logic              m_present [NUM_ENTRIES];
  logic [31:0]       m_tag     [NUM_ENTRIES];
  logic [31:0]       m_data    [NUM_ENTRIES];
  logic [IDX_W-1:0]  m_index;
  logic [ASID_W-1:0] m_asid;
  logic [31:0]       m_staged;
  logic [33:0]       exp_q [$];
  logic [33:0]       exp_r;
  int                err_cnt = 0;
  int                chk_cnt = 0;

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Result is {miss, fault, pa}; lowest hitting index wins
  function automatic logic [33:0] expect_rsp(input logic [31:0] va, input logic st,
                                             input logic [ASID_W-1:0] asid);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (m_present[i] && m_tag[i][31:12] == va[31:12]
          && (m_tag[i][1] || m_tag[i][11:2] == asid)) begin
        if (!m_data[i][1] || (st && !m_data[i][0])) begin
          return {1'b0, 1'b1, 32'd0};
        end
        return {1'b0, 1'b0, m_data[i][31:12], va[11:0]};
      end
    end
    return {1'b1, 1'b0, 32'd0};
  endfunction

  always @(negedge forever_cpuclk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        m_present[i] = 1'b0;
      end
      m_index = '0;
      m_asid  = '0;
      exp_q.delete();
    end else begin
      if (wb_ack && wb_cyc && wb_stb && wb_we) begin
        case (wb_adr)
          ADR_INDEX: m_index = wb_dat_w[IDX_W-1:0];
          ADR_TAG:   m_staged = wb_dat_w;
          ADR_ASID:  m_asid = wb_dat_w[ASID_W-1:0];
          ADR_DATA: begin
            m_present[m_index] = 1'b1;
            m_tag[m_index]     = m_staged;
            m_data[m_index]    = wb_dat_w;
          end
          ADR_CMD: begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
              if (wb_dat_w[0]) m_present[i] = 1'b0;
              if (wb_dat_w[1] && !m_tag[i][1] && m_tag[i][11:2] == m_asid) begin
                m_present[i] = 1'b0;
              end
            end
          end
          default: ;
        endcase
      end
      if (req_vld) begin
        exp_q.push_back(expect_rsp(req_va, req_st, m_asid));
      end
      if (rsp_vld) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t arrived with no lookup outstanding", $time);
          err_cnt++;
        end else begin
          exp_r = exp_q.pop_front();
          chk_cnt++;
          if (rsp_miss !== exp_r[33]) begin
            $display("Fail at %0t: rsp_miss expected %b, got %b", $time, exp_r[33], rsp_miss);
            err_cnt++;
          end
          if (rsp_fault !== exp_r[32]) begin
            $display("Fail at %0t: rsp_fault expected %b, got %b",
                     $time, exp_r[32], rsp_fault);
            err_cnt++;
          end
          if (rsp_pa !== exp_r[31:0]) begin
            $display("Fail at %0t: rsp_pa expected %h, got %h", $time, exp_r[31:0], rsp_pa);
            err_cnt++;
          end
        end
      end
    end
  end

endmodule

// ==== vlog.f ====
logic/mmu_pkg.sv
logic/tlb_if.sv
logic/tlb_ctrl.sv
logic/tlb_entry.sv
logic/tlb_hit_sel.sv
logic/mmu_tlb_top.sv
testbench/tlb_checker.sv
testbench/tlb_bus_assert.sv
testbench/tb_mmu_tlb.sv
